// File: sources.f
+incdir+hw
hw/xfer_pkg.sv
hw/block_fifo.sv
hw/burst_counter.sv
hw/dma_fsm.sv
hw/word_ram.sv
hw/xfer_top.sv
testbench/tb_clock.sv
testbench/xfer_tb.sv

// File: Makefile
# Verilator build and run for the block transfer testbench

LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sources.f --top-module xfer_tb -Mdir obj_dir -o xfer_sim

run: build
	./obj_dir/xfer_sim | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f sources.f --top-module xfer_tb

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/xfer_tb.sv
`default_nettype none
`include "xfer_settings.svh"

module xfer_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAIT_LIMIT = 400;   // cycles allowed per wait

	logic                    okClk;
	logic                    reset;
	xfer_pkg::host_ctrl_t    ctrl;
	logic                    pipe_in_write;
	logic [`XFER_DATA_W-1:0] pipe_in_data;
	logic                    pipe_in_ready;
	logic                    pipe_out_read;
	logic [`XFER_DATA_W-1:0] pipe_out_data;
	logic                    pipe_out_ready;
	xfer_pkg::status_t       status;

	int                      value_errors;
	int                      timeout_errors;
	int                      i;
	logic [`XFER_DATA_W-1:0] model_mem [2 ** `XFER_ADDR_W];
	logic [`XFER_DATA_W-1:0] model_in [$];    // host words not yet in memory
	logic [`XFER_DATA_W-1:0] model_out [$];   // words waiting at the outbound port
	logic [`XFER_ADDR_W-1:0] model_wr_ptr;
	logic [`XFER_ADDR_W-1:0] model_rd_ptr;

	tb_clock clock_i (.okClk(okClk), .reset(reset));

	xfer_top xfer_top_i (
		.okClk          (okClk),
		.reset          (reset),
		.ctrl           (ctrl),
		.pipe_in_write  (pipe_in_write),
		.pipe_in_data   (pipe_in_data),
		.pipe_in_ready  (pipe_in_ready),
		.pipe_out_read  (pipe_out_read),
		.pipe_out_data  (pipe_out_data),
		.pipe_out_ready (pipe_out_ready),
		.status         (status)
	);

	// ----------------------------------------
	// checks
	// ----------------------------------------
	task automatic check_bit(input string name, input logic expected, input logic actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[FAIL] %0d ns %s expected %b actual %b", $time, name, expected, actual);
		end
	endtask

	task automatic check_word(input string name, input logic [`XFER_DATA_W-1:0] expected,
			input logic [`XFER_DATA_W-1:0] actual);
		assert (actual === expected) else begin
			value_errors++;
			$display("[FAIL] %0d ns %s expected %h actual %h", $time, name, expected, actual);
		end
	endtask

	task automatic report_timeout(input string what);
		timeout_errors++;
		$display("timeout at %0d ns while waiting for %s", $time, what);
	endtask

	// ----------------------------------------
	// host actions
	// ----------------------------------------
	task automatic wait_reset_release();
		int n;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge okClk);
			if (!reset)
				break;
		end
		if (n == WAIT_LIMIT)
			report_timeout("reset to be released");
	endtask

	task automatic idle_cycles(input int cycles);
		repeat (cycles) @(posedge okClk);
		@(negedge okClk);
	endtask

	task automatic send_words(input int words, input bit keep);
		logic [`XFER_DATA_W-1:0] w;
		repeat (words) begin
			@(posedge okClk);
			w = $urandom;
			pipe_in_write <= 1'b1;
			pipe_in_data  <= w;
			if (keep)
				model_in.push_back(w);   // a dropped word is not kept
		end
		@(posedge okClk);
		pipe_in_write <= 1'b0;
	endtask

	task automatic pulse_fifo_reset(input logic [`XFER_ADDR_W-1:0] addr);
		@(posedge okClk);
		ctrl.fifo_reset <= 1'b1;
		ctrl.start_addr <= addr;
		@(posedge okClk);
		ctrl.fifo_reset <= 1'b0;
		@(negedge okClk);
		check_bit("status.in_empty", 1'b1, status.in_empty);
		check_bit("status.out_empty", 1'b1, status.out_empty);
		model_in.delete();
		model_out.delete();
		model_wr_ptr = addr;
		model_rd_ptr = addr;
	endtask

	task automatic write_to_memory();
		int n;
		@(posedge okClk);
		ctrl.pipe_write <= 1'b1;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge okClk);
			if (status.in_empty && !status.busy)
				break;
		end
		if (n == WAIT_LIMIT)
			report_timeout("the inbound FIFO to drain into memory");
		@(posedge okClk);
		ctrl.pipe_write <= 1'b0;
		while (model_in.size() > 0) begin
			model_mem[model_wr_ptr] = model_in.pop_front();
			model_wr_ptr = model_wr_ptr + 1'b1;   // wraps with the memory size
		end
	endtask

	task automatic read_burst();
		int n;
		@(posedge okClk);
		ctrl.pipe_read <= 1'b1;
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge okClk);
			if (status.busy)
				break;
		end
		if (n == WAIT_LIMIT)
			report_timeout("a read burst to start");
		@(posedge okClk);
		ctrl.pipe_read <= 1'b0;   // the running burst still completes
		for (n = 0; n < WAIT_LIMIT; n++) begin
			@(negedge okClk);
			if (!status.busy)
				break;
		end
		if (n == WAIT_LIMIT)
			report_timeout("a read burst to finish");
		@(posedge okClk);   // out_ready trails the count by a cycle
		repeat (`XFER_BURST) begin
			model_out.push_back(model_mem[model_rd_ptr]);
			model_rd_ptr = model_rd_ptr + 1'b1;
		end
	endtask

	task automatic drain_words(input int words);
		repeat (words) begin
			@(negedge okClk);
			check_bit("pipe_out_ready", model_out.size() >= `XFER_BLOCK, pipe_out_ready);
			check_word("pipe_out_data", model_out[0], pipe_out_data);
			void'(model_out.pop_front());
			@(posedge okClk);
			pipe_out_read <= 1'b1;
			@(posedge okClk);
			pipe_out_read <= 1'b0;
			@(posedge okClk);   // let out_ready follow the pop
		end
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		void'($urandom(96914));
		ctrl          <= '0;
		pipe_in_write <= 1'b0;
		pipe_in_data  <= '0;
		pipe_out_read <= 1'b0;
		value_errors   = 0;
		timeout_errors = 0;
		model_wr_ptr   = '0;
		model_rd_ptr   = '0;
		wait_reset_release();

		// state right after reset
		@(negedge okClk);
		check_bit("status.in_empty", 1'b1, status.in_empty);
		check_bit("status.out_empty", 1'b1, status.out_empty);
		check_bit("status.in_ready", 1'b1, status.in_ready);
		check_bit("status.out_ready", 1'b0, status.out_ready);
		check_bit("status.busy", 1'b0, status.busy);
		check_bit("status.in_full", 1'b0, status.in_full);
		check_bit("status.out_full", 1'b0, status.out_full);
		check_bit("status.spare", 1'b0, status.spare);
		check_bit("pipe_out_ready", 1'b0, pipe_out_ready);

		// inbound throttle while ctrl is zero so no bursts run
		send_words(44, 1'b1);
		idle_cycles(2);
		check_bit("pipe_in_ready", 1'b1, pipe_in_ready);
		send_words(1, 1'b1);
		idle_cycles(2);
		check_bit("pipe_in_ready", 1'b0, pipe_in_ready);
		send_words(19, 1'b1);
		@(negedge okClk);
		check_bit("status.in_full", 1'b1, status.in_full);
		send_words(1, 1'b0);   // 65th word falls on a full FIFO
		@(negedge okClk);
		check_bit("status.in_full", 1'b1, status.in_full);
		write_to_memory();
		repeat (8) read_burst();
		@(negedge okClk);
		check_bit("status.out_full", 1'b1, status.out_full);
		drain_words(64);
		@(negedge okClk);
		check_bit("status.out_empty", 1'b1, status.out_empty);

		// round trip of 32 words with out_ready rising at a block
		pulse_fifo_reset(8'h40);
		send_words(32, 1'b1);
		write_to_memory();
		for (i = 0; i < 4; i++) begin
			read_burst();
			@(negedge okClk);
			check_bit("pipe_out_ready", model_out.size() >= `XFER_BLOCK, pipe_out_ready);
		end
		drain_words(32);

		// fifo_reset over partly filled FIFOs
		pulse_fifo_reset(8'h00);
		read_burst();            // old words from the first fill
		drain_words(3);
		send_words(5, 1'b1);
		pulse_fifo_reset(8'hf8);   // new block wraps past the top of memory
		send_words(16, 1'b1);
		write_to_memory();
		read_burst();
		read_burst();
		drain_words(16);
		@(negedge okClk);
		check_bit("status.out_empty", 1'b1, status.out_empty);

		$display("value errors %0d, timeout errors %0d", value_errors, timeout_errors);
		if (value_errors == 0 && timeout_errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: testbench/tb_clock.sv
`default_nettype none

module tb_clock (
	output logic okClk,
	output logic reset
);
	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		okClk = 1'b0;
		forever #10 okClk = ~okClk;   // 20 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (10) @(posedge okClk);
		reset <= 1'b0;
	end

endmodule

`default_nettype wire

// File: hw/xfer_top.sv
`default_nettype none
`include "xfer_settings.svh"

module xfer_top (
	input  wire                        okClk,
	input  wire                        reset,
	input  wire  xfer_pkg::host_ctrl_t ctrl,
	input  wire                        pipe_in_write,
	input  wire  [`XFER_DATA_W-1:0]    pipe_in_data,
	output logic                       pipe_in_ready,
	input  wire                        pipe_out_read,
	output logic [`XFER_DATA_W-1:0]    pipe_out_data,
	output logic                       pipe_out_ready,
	output xfer_pkg::status_t          status
);

	logic [`XFER_DATA_W-1:0] in_data;
	logic [`XFER_DATA_W-1:0] out_data;
	logic [`XFER_CNT_W-1:0]  in_count;
	logic [`XFER_CNT_W-1:0]  out_count;
	logic                    in_full, in_empty;
	logic                    out_full, out_empty;
	logic                    in_pop, out_push;
	logic                    cnt_load, cnt_step;
	logic                    last;
	logic                    busy;
	logic [`XFER_ADDR_W-1:0] addr;
	xfer_pkg::xfer_op_t      op;
	xfer_pkg::wb_req_t       wb_req;
	xfer_pkg::wb_rsp_t       wb_rsp;

	// ----------------------------------------
	// host pipes
	// ----------------------------------------
	block_fifo in_fifo (
		.okClk       (okClk),
		.reset       (reset),
		.clear       (cnt_load),        // fifo_reset seen from IDLE
		.push        (pipe_in_write),
		.pop         (in_pop),
		.din         (pipe_in_data),
		.dout        (in_data),
		.count       (in_count),
		.full        (in_full),
		.empty       (in_empty),
		.block_space (pipe_in_ready),
		.block_avail ()
	);

	block_fifo out_fifo (
		.okClk       (okClk),
		.reset       (reset),
		.clear       (cnt_load),
		.push        (out_push),
		.pop         (pipe_out_read),
		.din         (out_data),
		.dout        (pipe_out_data),
		.count       (out_count),
		.full        (out_full),
		.empty       (out_empty),
		.block_space (),
		.block_avail (pipe_out_ready)
	);

	// ----------------------------------------
	// DMA and memory
	// ----------------------------------------
	burst_counter counter_i (
		.okClk      (okClk),
		.reset      (reset),
		.load       (cnt_load),
		.start_addr (ctrl.start_addr),
		.step       (cnt_step),
		.op         (op),
		.addr       (addr),
		.last       (last)
	);

	dma_fsm dma_i (
		.okClk     (okClk),
		.reset     (reset),
		.ctrl      (ctrl),
		.in_count  (in_count),
		.out_count (out_count),
		.in_data   (in_data),
		.in_pop    (in_pop),
		.out_push  (out_push),
		.out_data  (out_data),
		.addr      (addr),
		.last      (last),
		.op        (op),
		.cnt_load  (cnt_load),
		.cnt_step  (cnt_step),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.busy      (busy)
	);

	word_ram ram_i (
		.okClk  (okClk),
		.reset  (reset),
		.wb_req (wb_req),
		.wb_rsp (wb_rsp)
	);

	assign status = '{
		in_full:   in_full,
		in_empty:  in_empty,
		out_full:  out_full,
		out_empty: out_empty,
		in_ready:  pipe_in_ready,
		out_ready: pipe_out_ready,
		busy:      busy,
		spare:     1'b0
	};

endmodule

`default_nettype wire

// File: hw/word_ram.sv
`default_nettype none
`include "xfer_settings.svh"

module word_ram (
	input  wire                     okClk,
	input  wire                     reset,
	input  wire  xfer_pkg::wb_req_t wb_req,
	output xfer_pkg::wb_rsp_t       wb_rsp
);

	localparam int WORDS = 2 ** `XFER_ADDR_W;

	logic [`XFER_DATA_W-1:0] mem [WORDS];
	logic [`XFER_DATA_W-1:0] dat_q;
	logic                    ack_q;
	logic                    access;

	// a new access is a strobe not already answered
	assign access = wb_req.cyc && wb_req.stb && !ack_q;

	always_ff @(posedge okClk) begin
		if (reset)
			ack_q <= 1'b0;
		else
			ack_q <= access;   // one cycle high per beat
	end

	always_ff @(posedge okClk) begin
		if (access) begin
			if (wb_req.we)
				mem[wb_req.adr] <= wb_req.dat;
			dat_q <= mem[wb_req.adr];
		end
	end

	always_comb begin
		wb_rsp.ack = ack_q;
		wb_rsp.dat = dat_q;
	end

endmodule

`default_nettype wire

// File: hw/dma_fsm.sv
`default_nettype none
`include "xfer_settings.svh"

module dma_fsm (
	input  wire                        okClk,
	input  wire                        reset,
	input  wire  xfer_pkg::host_ctrl_t ctrl,
	input  wire  [`XFER_CNT_W-1:0]     in_count,
	input  wire  [`XFER_CNT_W-1:0]     out_count,
	input  wire  [`XFER_DATA_W-1:0]    in_data,
	output logic                       in_pop,
	output logic                       out_push,
	output logic [`XFER_DATA_W-1:0]    out_data,
	input  wire  [`XFER_ADDR_W-1:0]    addr,
	input  wire                        last,
	output xfer_pkg::xfer_op_t         op,
	output logic                       cnt_load,
	output logic                       cnt_step,
	output xfer_pkg::wb_req_t          wb_req,
	input  wire  xfer_pkg::wb_rsp_t    wb_rsp,
	output logic                       busy
);

	xfer_pkg::dma_state_t    state;
	xfer_pkg::xfer_op_t      op_q;
	logic [`XFER_DATA_W-1:0] wr_q;     // word on the bus during a write beat
	logic [`XFER_DATA_W-1:0] rd_q;     // word read back, pushed next cycle
	logic                    push_q;
	logic                    can_write;
	logic                    can_read;
	logic                    on_bus;

	assign can_write = ctrl.pipe_write && (in_count >= `XFER_BURST);
	assign can_read  = ctrl.pipe_read && (out_count <= `XFER_FIFO_DEPTH - `XFER_BURST);

	// ----------------------------------------
	// operation choice and beat sequencing
	// ----------------------------------------
	always_ff @(posedge okClk) begin
		if (reset) begin
			state  <= xfer_pkg::IDLE;
			op_q   <= xfer_pkg::OP_NONE;
			push_q <= 1'b0;
		end else begin
			push_q <= 1'b0;
			case (state)
			xfer_pkg::IDLE: begin
				if (!ctrl.fifo_reset) begin   // a reset request holds the DMA here
					if (can_write) begin
						state <= xfer_pkg::WR_FETCH;
						op_q  <= xfer_pkg::OP_WRITE;
					end else if (can_read) begin
						state <= xfer_pkg::RD_BEAT;
						op_q  <= xfer_pkg::OP_READ;
					end
				end
			end
			xfer_pkg::WR_FETCH: begin
				state <= xfer_pkg::WR_BEAT;
			end
			xfer_pkg::WR_BEAT: begin
				if (wb_rsp.ack && last) begin
					state <= xfer_pkg::IDLE;
					op_q  <= xfer_pkg::OP_NONE;
				end
			end
			xfer_pkg::RD_BEAT: begin
				if (wb_rsp.ack) begin
					push_q <= 1'b1;
					if (last)
						state <= xfer_pkg::RD_PUSH;
				end
			end
			xfer_pkg::RD_PUSH: begin
				state <= xfer_pkg::IDLE;   // out_count is settled by the next pick
				op_q  <= xfer_pkg::OP_NONE;
			end
			default: begin
				state <= xfer_pkg::IDLE;
				op_q  <= xfer_pkg::OP_NONE;
			end
			endcase
		end
	end

	// the next inbound word is taken while the current beat is acked,
	// so the write register is never empty during a burst
	always_ff @(posedge okClk) begin
		if (in_pop)
			wr_q <= in_data;
		if (state == xfer_pkg::RD_BEAT && wb_rsp.ack)
			rd_q <= wb_rsp.dat;
	end

	assign in_pop = (state == xfer_pkg::WR_FETCH) ||
	                (state == xfer_pkg::WR_BEAT && wb_rsp.ack && !last);

	assign on_bus   = (state == xfer_pkg::WR_BEAT) || (state == xfer_pkg::RD_BEAT);
	assign cnt_step = on_bus && wb_rsp.ack;
	assign cnt_load = (state == xfer_pkg::IDLE) && ctrl.fifo_reset;
	assign out_push = push_q;
	assign out_data = rd_q;
	assign op       = op_q;
	assign busy     = (state != xfer_pkg::IDLE);

	// cyc and stb stay up across the whole burst
	always_comb begin
		wb_req.cyc = on_bus;
		wb_req.stb = on_bus;
		wb_req.we  = (state == xfer_pkg::WR_BEAT);
		wb_req.adr = addr;
		wb_req.dat = wr_q;
	end

endmodule

`default_nettype wire

// File: hw/burst_counter.sv
`default_nettype none
`include "xfer_settings.svh"

module burst_counter (
	input  wire                      okClk,
	input  wire                      reset,
	input  wire                      load,
	input  wire  [`XFER_ADDR_W-1:0]  start_addr,
	input  wire                      step,
	input  wire  xfer_pkg::xfer_op_t op,
	output logic [`XFER_ADDR_W-1:0]  addr,
	output logic                     last
);

	localparam int BEAT_W = $clog2(`XFER_BURST);

	logic [`XFER_ADDR_W-1:0] wr_ptr;   // next memory word to write
	logic [`XFER_ADDR_W-1:0] rd_ptr;   // next memory word to read back
	logic [BEAT_W-1:0]       beat;

	always_ff @(posedge okClk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			beat   <= '0;
		end else if (load) begin
			wr_ptr <= start_addr;
			rd_ptr <= start_addr;
			beat   <= '0;
		end else if (step) begin
			if (op == xfer_pkg::OP_WRITE)
				wr_ptr <= wr_ptr + 1'b1;   // wraps with the memory size
			if (op == xfer_pkg::OP_READ)
				rd_ptr <= rd_ptr + 1'b1;
			beat <= last ? '0 : beat + 1'b1;
		end
	end

	assign addr = (op == xfer_pkg::OP_READ) ? rd_ptr : wr_ptr;
	assign last = (beat == BEAT_W'(`XFER_BURST - 1));

endmodule

`default_nettype wire

// File: hw/block_fifo.sv
`default_nettype none
`include "xfer_settings.svh"

module block_fifo (
	input  wire                      okClk,
	input  wire                      reset,
	input  wire                      clear,
	input  wire                      push,
	input  wire                      pop,
	input  wire  [`XFER_DATA_W-1:0]  din,
	output logic [`XFER_DATA_W-1:0]  dout,
	output logic [`XFER_CNT_W-1:0]   count,
	output logic                     full,
	output logic                     empty,
	output logic                     block_space,
	output logic                     block_avail
);

	localparam int PTR_W = $clog2(`XFER_FIFO_DEPTH);

	logic [`XFER_DATA_W-1:0] mem [`XFER_FIFO_DEPTH];
	logic [PTR_W-1:0]        wr_ptr;
	logic [PTR_W-1:0]        rd_ptr;
	logic                    do_push;
	logic                    do_pop;

	assign full    = (count == `XFER_FIFO_DEPTH);
	assign empty   = (count == 0);
	assign do_push = push && !full;    // writes into a full FIFO are dropped
	assign do_pop  = pop && !empty;
	assign dout    = mem[rd_ptr];      // head shows before the pop

	always_ff @(posedge okClk) begin
		if (do_push)
			mem[wr_ptr] <= din;
	end

	always_ff @(posedge okClk) begin
		if (reset || clear) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			block_space <= 1'b1;     // empty FIFO has room for a block
			block_avail <= 1'b0;
		end else begin
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;

			// ----------------------------------------
			// block throttle, one cycle behind count
			// ----------------------------------------
			block_space <= (count <= `XFER_FIFO_DEPTH - `XFER_HEADROOM - `XFER_BLOCK);
			block_avail <= (count >= `XFER_BLOCK);
		end
	end

endmodule

`default_nettype wire

// File: hw/xfer_pkg.sv
`default_nettype none
`include "xfer_settings.svh"

package xfer_pkg;

	// host control word, held as a level
	typedef struct packed {
		logic                    pipe_write;  // allow inbound to memory bursts
		logic                    pipe_read;   // allow memory to outbound bursts
		logic                    fifo_reset;  // empty FIFOs, reload pointers
		logic [`XFER_ADDR_W-1:0] start_addr;
	} host_ctrl_t;

	// ----------------------------------------
	// Wishbone classic
	// ----------------------------------------
	typedef struct packed {
		logic                    cyc;
		logic                    stb;
		logic                    we;
		logic [`XFER_ADDR_W-1:0] adr;
		logic [`XFER_DATA_W-1:0] dat;
	} wb_req_t;

	typedef struct packed {
		logic                    ack;
		logic [`XFER_DATA_W-1:0] dat;
	} wb_rsp_t;

	// status byte, same order as the old LED monitor
	typedef struct packed {
		logic in_full;
		logic in_empty;
		logic out_full;
		logic out_empty;
		logic in_ready;
		logic out_ready;
		logic busy;
		logic spare;   // always zero
	} status_t;

	typedef enum logic [2:0] {
		IDLE,
		WR_FETCH,   // first inbound word into the write register
		WR_BEAT,
		RD_BEAT,
		RD_PUSH     // last read word goes outbound
	} dma_state_t;

	typedef enum logic [1:0] {
		OP_NONE,
		OP_WRITE,
		OP_READ
	} xfer_op_t;

endpackage

`default_nettype wire

// File: hw/xfer_settings.svh
`ifndef XFER_SETTINGS_SVH
`define XFER_SETTINGS_SVH

// ----------------------------------------
// datapath and memory
// ----------------------------------------
`define XFER_DATA_W      32     // host and memory word width
`define XFER_ADDR_W      8      // word address, 256 words of memory

// ----------------------------------------
// FIFOs and block throttle
// ----------------------------------------
`define XFER_FIFO_DEPTH  64     // words per FIFO, power of two
`define XFER_BLOCK       16     // host block size in words
`define XFER_HEADROOM    4      // covers the late ready flag
`define XFER_CNT_W       ($clog2(`XFER_FIFO_DEPTH + 1))  // count holds 0 to depth

// ----------------------------------------
// DMA
// ----------------------------------------
`define XFER_BURST       8      // words per memory burst

`endif
